// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

   // Integer register and data path width.
   localparam int XLEN = 64;

   // Major opcodes decoded by the core.
   typedef enum logic [6:0]
   {
      OP_LUI   = 7'h37,
      OP_IMM   = 7'h13,
      OP_REG   = 7'h33,
      OP_LOAD  = 7'h03,
      OP_STORE = 7'h23,
      OP_TRAP  = 7'h6b
   } opcode_e;

   // Operations of the execute stage ALU.
   typedef enum logic [2:0]
   {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

endpackage

`default_nettype wire

// File: rtl/trace_pkg.sv
`default_nettype none

package trace_pkg;

   // Opcode of the instruction that ends a run.
   localparam logic [6:0] TRAP_OPCODE = core_pkg::OP_TRAP;

   // One retired instruction as seen at write-back.
   typedef struct packed
   {
      logic                      valid;
      logic [core_pkg::XLEN-1:0] pc;
      logic [31:0]               insn;
      logic                      wen;
      logic [4:0]                rd;
      logic [core_pkg::XLEN-1:0] wdata;
      logic                      trap;
   } commit_t;

endpackage

`default_nettype wire

// File: rtl/exec_wb_if.sv
`default_nettype none

interface exec_wb_if;
   import core_pkg::*;

   logic            valid;
   logic [XLEN-1:0] pc;
   logic [31:0]     insn;
   logic [4:0]      rd;
   logic            rf_we;
   logic [XLEN-1:0] result;
   logic            mem_re;
   logic            mem_we;
   logic [XLEN-1:0] store_data;
   logic            is_trap;

   modport execute (output valid, pc, insn, rd, rf_we, result,
                    output mem_re, mem_we, store_data, is_trap);

   modport wb (input valid, pc, insn, rd, rf_we, result,
               input mem_re, mem_we, store_data, is_trap);

endinterface

`default_nettype wire

// File: rtl/instr_mem.sv
`default_nettype none

module instr_mem
#(
   parameter int IRAM_AW = 8
)
(
   input  wire logic                      clock,
   input  wire logic                      rst,
   input  wire logic                      i_load_we,
   input  wire logic [IRAM_AW-1:0]        i_load_addr,
   input  wire logic [31:0]               i_load_insn,
   input  wire logic                      i_re,
   input  wire logic [IRAM_AW-1:0]        i_addr,
   output logic      [31:0]               o_insn,
   output logic      [core_pkg::XLEN-1:0] o_pc,
   output logic                           o_valid
);
   import core_pkg::*;

   logic [31:0] mem [2**IRAM_AW];

   // Program load port, used while the core is idle.
   always_ff @(posedge clock)
   begin
      if (i_load_we)
         mem[i_load_addr] <= i_load_insn;
   end

   always_ff @(posedge clock)
   begin
      if (rst)
         o_valid <= 1'b0;
      else
         o_valid <= i_re;
   end

   // The pc is the word address of the fetched instruction.
   always_ff @(posedge clock)
   begin
      if (i_re)
      begin
         o_insn <= mem[i_addr];
         o_pc   <= {{(XLEN-IRAM_AW){1'b0}}, i_addr};
      end
   end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none

module fetch_stage
#(
   parameter int IRAM_AW = 8
)
(
   input  wire logic               clock,
   input  wire logic               rst,
   input  wire logic               i_run,
   input  wire logic               i_halt,
   output logic                    o_re,
   output logic      [IRAM_AW-1:0] o_addr
);

   logic [IRAM_AW-1:0] pc;
   logic               halted;

   // Fetch stops in the same cycle that halt is raised.
   assign o_re   = i_run & ~i_halt & ~halted;
   assign o_addr = pc;

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         pc     <= '0;
         halted <= 1'b0;
      end
      else
      begin
         if (i_halt)
            halted <= 1'b1;
         if (o_re)
            pc <= pc + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file
(
   input  wire logic                      clock,
   input  wire logic                      rst,
   input  wire logic [4:0]                i_rs1,
   input  wire logic [4:0]                i_rs2,
   output logic      [core_pkg::XLEN-1:0] o_rs1_data,
   output logic      [core_pkg::XLEN-1:0] o_rs2_data,
   input  wire logic                      i_we,
   input  wire logic [4:0]                i_rd,
   input  wire logic [core_pkg::XLEN-1:0] i_wd
);
   import core_pkg::*;

   logic [XLEN-1:0] regs [32];

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end
      else if (i_we && i_rd != 5'd0)
         regs[i_rd] <= i_wd;
   end

   assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
   assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

module execute_stage
(
   input  wire logic                      clock,
   input  wire logic                      rst,
   input  wire logic                      i_valid,
   input  wire logic [core_pkg::XLEN-1:0] i_pc,
   input  wire logic [31:0]               i_insn,
   output logic      [4:0]                o_rs1,
   output logic      [4:0]                o_rs2,
   input  wire logic [core_pkg::XLEN-1:0] i_rs1_data,
   input  wire logic [core_pkg::XLEN-1:0] i_rs2_data,
   input  wire logic                      i_fwd_we,
   input  wire logic [4:0]                i_fwd_rd,
   input  wire logic [core_pkg::XLEN-1:0] i_fwd_data,
   output logic                           o_halt,
   exec_wb_if.execute                     ex
);
   import core_pkg::*;
   import trace_pkg::*;

   opcode_e         opcode;
   alu_op_e         alu_op;
   alu_op_e         alu_f3;
   logic [2:0]      funct3;
   logic            f3_ok;
   logic            is_trap;
   logic            rf_we;
   logic            mem_re;
   logic            mem_we;
   logic            accept;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_s;
   logic [XLEN-1:0] imm_u;
   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] rs2_val;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_out;
   logic [XLEN-1:0] result;

   assign opcode  = opcode_e'(i_insn[6:0]);
   assign funct3  = i_insn[14:12];
   assign is_trap = (i_insn[6:0] == TRAP_OPCODE);

   // The trap reads its code from x10 through the rs1 port.
   assign o_rs1 = is_trap ? 5'd10 : i_insn[19:15];
   assign o_rs2 = i_insn[24:20];

   assign imm_i = {{(XLEN-12){i_insn[31]}}, i_insn[31:20]};
   assign imm_s = {{(XLEN-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
   assign imm_u = {{(XLEN-32){i_insn[31]}}, i_insn[31:12], 12'b0};

   // Bypass from the instruction being written back this cycle.
   assign op_a = (i_fwd_we && i_fwd_rd != 5'd0 && i_fwd_rd == o_rs1) ? i_fwd_data
                                                                      : i_rs1_data;
   assign rs2_val = (i_fwd_we && i_fwd_rd != 5'd0 && i_fwd_rd == o_rs2) ? i_fwd_data
                                                                         : i_rs2_data;

   always_comb
   begin
      f3_ok  = 1'b1;
      alu_f3 = ALU_ADD;
      case (funct3)
         3'b000: alu_f3 = (opcode == OP_REG && i_insn[30]) ? ALU_SUB : ALU_ADD;
         3'b100: alu_f3 = ALU_XOR;
         3'b110: alu_f3 = ALU_OR;
         3'b111: alu_f3 = ALU_AND;
         default: f3_ok = 1'b0;
      endcase
   end

   always_comb
   begin
      alu_op = ALU_ADD;
      op_b   = imm_i;
      rf_we  = 1'b0;
      mem_re = 1'b0;
      mem_we = 1'b0;
      case (opcode)
         OP_LUI:
         begin
            alu_op = ALU_PASS_B;
            op_b   = imm_u;
            rf_we  = 1'b1;
         end
         OP_IMM:
         begin
            alu_op = alu_f3;
            rf_we  = f3_ok;
         end
         OP_REG:
         begin
            alu_op = alu_f3;
            op_b   = rs2_val;
            rf_we  = f3_ok;
         end
         OP_LOAD:
         begin
            rf_we  = (funct3 == 3'b011);
            mem_re = (funct3 == 3'b011);
         end
         OP_STORE:
         begin
            op_b   = imm_s;
            mem_we = (funct3 == 3'b011);
         end
         default: ;
      endcase
   end

   always_comb
   begin
      case (alu_op)
         ALU_ADD:    alu_out = op_a + op_b;
         ALU_SUB:    alu_out = op_a - op_b;
         ALU_AND:    alu_out = op_a & op_b;
         ALU_OR:     alu_out = op_a | op_b;
         ALU_XOR:    alu_out = op_a ^ op_b;
         default:    alu_out = op_b;
      endcase
   end

   assign result = is_trap ? op_a : alu_out;

   // The instruction fetched behind a trap is dropped here.
   assign accept = i_valid & ~o_halt;

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         ex.valid <= 1'b0;
         o_halt   <= 1'b0;
      end
      else
      begin
         ex.valid <= accept;
         if (accept && is_trap)
            o_halt <= 1'b1;
      end
   end

   always_ff @(posedge clock)
   begin
      ex.pc         <= i_pc;
      ex.insn       <= i_insn;
      ex.rd         <= i_insn[11:7];
      ex.rf_we      <= rf_we;
      ex.result     <= result;
      ex.mem_re     <= mem_re;
      ex.mem_we     <= mem_we;
      ex.store_data <= rs2_val;
      ex.is_trap    <= is_trap;
   end

endmodule

`default_nettype wire

// File: rtl/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage
#(
   parameter int DRAM_AW = 8
)
(
   input  wire logic                      clock,
   input  wire logic                      rst,
   exec_wb_if.wb                          wb,
   output logic                           o_rf_we,
   output logic      [4:0]                o_rf_rd,
   output logic      [core_pkg::XLEN-1:0] o_rf_wd,
   output trace_pkg::commit_t             o_commit
);
   import core_pkg::*;
   import trace_pkg::*;

   logic [XLEN-1:0]    dram [2**DRAM_AW];
   logic [DRAM_AW-1:0] dram_idx;
   logic [XLEN-1:0]    load_data;

   // Byte address to doubleword index.
   assign dram_idx = wb.result[DRAM_AW+2:3];

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         for (int i = 0; i < 2**DRAM_AW; i++)
            dram[i] <= '0;
      end
      else if (wb.valid && wb.mem_we)
         dram[dram_idx] <= wb.store_data;
   end

   // Loads read in the same cycle so the data can be forwarded.
   assign load_data = dram[dram_idx];

   assign o_rf_we = wb.valid & wb.rf_we;
   assign o_rf_rd = wb.rd;
   assign o_rf_wd = wb.mem_re ? load_data : wb.result;

   always_comb
   begin
      o_commit       = '0;
      o_commit.valid = wb.valid;
      o_commit.pc    = wb.pc;
      o_commit.insn  = wb.insn;
      o_commit.wen   = o_rf_we & (|wb.rd);
      o_commit.rd    = wb.rd;
      o_commit.wdata = o_rf_wd;
      o_commit.trap  = wb.valid & wb.is_trap;
   end

endmodule

`default_nettype wire

// File: rtl/commit_monitor.sv
`default_nettype none

module commit_monitor
(
   input  wire logic                      clock,
   input  wire logic                      rst,
   input  trace_pkg::commit_t             i_commit,
   output logic                           o_commit_valid,
   output logic      [core_pkg::XLEN-1:0] o_commit_pc,
   output logic      [31:0]               o_commit_insn,
   output logic                           o_commit_wen,
   output logic      [4:0]                o_commit_rd,
   output logic      [core_pkg::XLEN-1:0] o_commit_wdata,
   output logic                           o_trap_valid,
   output logic      [7:0]                o_trap_code,
   output logic      [core_pkg::XLEN-1:0] o_cycle_cnt,
   output logic      [core_pkg::XLEN-1:0] o_instr_cnt
);

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         o_commit_valid <= 1'b0;
         o_trap_valid   <= 1'b0;
         o_cycle_cnt    <= '0;
         o_instr_cnt    <= '0;
      end
      else
      begin
         o_commit_valid <= i_commit.valid;
         o_trap_valid   <= i_commit.valid & i_commit.trap;
         o_cycle_cnt    <= o_cycle_cnt + 1'b1;
         // Counts commits already reported, so the trap sees the ones before it.
         if (o_commit_valid)
            o_instr_cnt <= o_instr_cnt + 1'b1;
      end
   end

   always_ff @(posedge clock)
   begin
      o_commit_pc    <= i_commit.pc;
      o_commit_insn  <= i_commit.insn;
      o_commit_wen   <= i_commit.wen;
      o_commit_rd    <= i_commit.rd;
      o_commit_wdata <= i_commit.wdata;
      o_trap_code    <= i_commit.wdata[7:0];
   end

endmodule

`default_nettype wire

// File: rtl/sim_top.sv
`default_nettype none

module sim_top
#(
   parameter int IRAM_AW = 8,
   parameter int DRAM_AW = 8
)
(
   input  wire logic                      clock,
   input  wire logic                      rst,
   input  wire logic                      i_run,
   input  wire logic                      i_load_we,
   input  wire logic [IRAM_AW-1:0]        i_load_addr,
   input  wire logic [31:0]               i_load_insn,
   output logic                           o_commit_valid,
   output logic      [core_pkg::XLEN-1:0] o_commit_pc,
   output logic      [31:0]               o_commit_insn,
   output logic                           o_commit_wen,
   output logic      [4:0]                o_commit_rd,
   output logic      [core_pkg::XLEN-1:0] o_commit_wdata,
   output logic                           o_trap_valid,
   output logic      [7:0]                o_trap_code,
   output logic      [core_pkg::XLEN-1:0] o_cycle_cnt,
   output logic      [core_pkg::XLEN-1:0] o_instr_cnt
);
   import core_pkg::*;
   import trace_pkg::*;

   logic               iram_re;
   logic [IRAM_AW-1:0] iram_addr;
   logic [31:0]        fetch_insn;
   logic [XLEN-1:0]    fetch_pc;
   logic               fetch_valid;
   logic               halt;
   logic [4:0]         rs1;
   logic [4:0]         rs2;
   logic [XLEN-1:0]    rs1_data;
   logic [XLEN-1:0]    rs2_data;
   logic               rf_we;
   logic [4:0]         rf_rd;
   logic [XLEN-1:0]    rf_wd;
   commit_t            commit;

   exec_wb_if ex_wb ();

   fetch_stage #(.IRAM_AW(IRAM_AW)) u_fetch
   (
      .clock       (clock),
      .rst         (rst),
      .i_run       (i_run),
      .i_halt      (halt),
      .o_re        (iram_re),
      .o_addr      (iram_addr)
   );

   instr_mem #(.IRAM_AW(IRAM_AW)) u_iram
   (
      .clock       (clock),
      .rst         (rst),
      .i_load_we   (i_load_we),
      .i_load_addr (i_load_addr),
      .i_load_insn (i_load_insn),
      .i_re        (iram_re),
      .i_addr      (iram_addr),
      .o_insn      (fetch_insn),
      .o_pc        (fetch_pc),
      .o_valid     (fetch_valid)
   );

   reg_file u_rf
   (
      .clock       (clock),
      .rst         (rst),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .o_rs1_data  (rs1_data),
      .o_rs2_data  (rs2_data),
      .i_we        (rf_we),
      .i_rd        (rf_rd),
      .i_wd        (rf_wd)
   );

   execute_stage u_exec
   (
      .clock       (clock),
      .rst         (rst),
      .i_valid     (fetch_valid),
      .i_pc        (fetch_pc),
      .i_insn      (fetch_insn),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .i_rs1_data  (rs1_data),
      .i_rs2_data  (rs2_data),
      .i_fwd_we    (rf_we),
      .i_fwd_rd    (rf_rd),
      .i_fwd_data  (rf_wd),
      .o_halt      (halt),
      .ex          (ex_wb)
   );

   mem_wb_stage #(.DRAM_AW(DRAM_AW)) u_mem_wb
   (
      .clock       (clock),
      .rst         (rst),
      .wb          (ex_wb),
      .o_rf_we     (rf_we),
      .o_rf_rd     (rf_rd),
      .o_rf_wd     (rf_wd),
      .o_commit    (commit)
   );

   commit_monitor u_monitor
   (
      .clock          (clock),
      .rst            (rst),
      .i_commit       (commit),
      .o_commit_valid (o_commit_valid),
      .o_commit_pc    (o_commit_pc),
      .o_commit_insn  (o_commit_insn),
      .o_commit_wen   (o_commit_wen),
      .o_commit_rd    (o_commit_rd),
      .o_commit_wdata (o_commit_wdata),
      .o_trap_valid   (o_trap_valid),
      .o_trap_code    (o_trap_code),
      .o_cycle_cnt    (o_cycle_cnt),
      .o_instr_cnt    (o_instr_cnt)
   );

endmodule

`default_nettype wire

// File: verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

   // The last entry is the trap.
   localparam int NUM_ENTRIES = 22;

   entry_t prog_table [NUM_ENTRIES];

   // Columns: program word, then the expected pc, wen, rd and wdata of its commit.
   // For the trap the wdata column holds x10, whose low byte is the trap code.
   task automatic fill_table();
      prog_table[0]  = table_entry(itype_word(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5),
                                   64'd0, 1'b1, 5'd1, 64'd5);
      prog_table[1]  = table_entry(itype_word(OP_IMM, 3'b000, 5'd2, 5'd1, 12'd7),
                                   64'd1, 1'b1, 5'd2, 64'd12);
      prog_table[2]  = table_entry(rtype_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2),
                                   64'd2, 1'b1, 5'd3, 64'd17);
      prog_table[3]  = table_entry(rtype_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1),
                                   64'd3, 1'b1, 5'd4, 64'd12);
      prog_table[4]  = table_entry(itype_word(OP_IMM, 3'b100, 5'd5, 5'd4, 12'h0ff),
                                   64'd4, 1'b1, 5'd5, 64'h0f3);
      prog_table[5]  = table_entry(itype_word(OP_IMM, 3'b110, 5'd6, 5'd5, 12'h100),
                                   64'd5, 1'b1, 5'd6, 64'h1f3);
      prog_table[6]  = table_entry(itype_word(OP_IMM, 3'b111, 5'd7, 5'd6, 12'h0f0),
                                   64'd6, 1'b1, 5'd7, 64'h0f0);
      prog_table[7]  = table_entry(utype_word(5'd8, 20'h12345),
                                   64'd7, 1'b1, 5'd8, 64'h1234_5000);
      prog_table[8]  = table_entry(rtype_word(7'h00, 3'b110, 5'd9, 5'd8, 5'd6),
                                   64'd8, 1'b1, 5'd9, 64'h1234_51f3);
      prog_table[9]  = table_entry(rtype_word(7'h00, 3'b100, 5'd11, 5'd9, 5'd8),
                                   64'd9, 1'b1, 5'd11, 64'h1f3);
      prog_table[10] = table_entry(rtype_word(7'h00, 3'b111, 5'd12, 5'd9, 5'd7),
                                   64'd10, 1'b1, 5'd12, 64'h0f0);
      prog_table[11] = table_entry(itype_word(OP_IMM, 3'b000, 5'd0, 5'd1, 12'd3),
                                   64'd11, 1'b0, 5'd0, 64'd8);
      prog_table[12] = table_entry(utype_word(5'd13, 20'hfffff),
                                   64'd12, 1'b1, 5'd13, 64'hffff_ffff_ffff_f000);
      prog_table[13] = table_entry(itype_word(OP_IMM, 3'b000, 5'd14, 5'd0, 12'hfff),
                                   64'd13, 1'b1, 5'd14, 64'hffff_ffff_ffff_ffff);
      prog_table[14] = table_entry(stype_word(5'd0, 5'd9, 12'd16),
                                   64'd14, 1'b0, 5'd0, 64'd0);
      prog_table[15] = table_entry(itype_word(OP_LOAD, 3'b011, 5'd15, 5'd0, 12'd16),
                                   64'd15, 1'b1, 5'd15, 64'h1234_51f3);
      prog_table[16] = table_entry(rtype_word(7'h00, 3'b000, 5'd16, 5'd15, 5'd1),
                                   64'd16, 1'b1, 5'd16, 64'h1234_51f8);
      prog_table[17] = table_entry(itype_word(OP_LOAD, 3'b011, 5'd17, 5'd0, 12'd40),
                                   64'd17, 1'b1, 5'd17, 64'd0);
      prog_table[18] = table_entry(itype_word(7'h0b, 3'b000, 5'd14, 5'd1, 12'd1),
                                   64'd18, 1'b0, 5'd0, 64'd0);
      prog_table[19] = table_entry(itype_word(OP_IMM, 3'b000, 5'd18, 5'd14, 12'd1),
                                   64'd19, 1'b1, 5'd18, 64'd0);
      prog_table[20] = table_entry(itype_word(OP_IMM, 3'b000, 5'd10, 5'd0, 12'h05a),
                                   64'd20, 1'b1, 5'd10, 64'h5a);
      prog_table[21] = table_entry(itype_word(TRAP_OPCODE, 3'b000, 5'd0, 5'd0, 12'd0),
                                   64'd21, 1'b0, 5'd0, 64'h5a);
   endtask

`endif

// File: verif/tb_sim_top.sv
`default_nettype none

module tb_sim_top;
   timeunit 1ns;
   timeprecision 1ps;
   import core_pkg::*;
   import trace_pkg::*;

   localparam int IRAM_AW = 8;
   localparam int DRAM_AW = 8;

   typedef struct packed
   {
      logic [31:0]     insn;
      logic [XLEN-1:0] pc;
      logic            wen;
      logic [4:0]      rd;
      logic [XLEN-1:0] wdata;
   } entry_t;

   logic               clock;
   logic               rst;
   logic               run;
   logic               load_we;
   logic [IRAM_AW-1:0] load_addr;
   logic [31:0]        load_insn;
   logic               commit_valid;
   logic [XLEN-1:0]    commit_pc;
   logic [31:0]        commit_insn;
   logic               commit_wen;
   logic [4:0]         commit_rd;
   logic [XLEN-1:0]    commit_wdata;
   logic               trap_valid;
   logic [7:0]         trap_code;
   logic [XLEN-1:0]    cycle_cnt;
   logic [XLEN-1:0]    instr_cnt;

   int                 commit_idx;
   int                 run_cycles;
   logic               trap_seen;
   int                 sample_cycle;
   int                 first_cycle;

   function automatic logic [31:0] itype_word(logic [6:0] op, logic [2:0] f3,
                                              logic [4:0] rd, logic [4:0] rs1,
                                              logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] rtype_word(logic [6:0] f7, logic [2:0] f3,
                                              logic [4:0] rd, logic [4:0] rs1,
                                              logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'(OP_REG)};
   endfunction

   // Doubleword store, funct3 011.
   function automatic logic [31:0] stype_word(logic [4:0] rs1, logic [4:0] rs2,
                                              logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'(OP_STORE)};
   endfunction

   function automatic logic [31:0] utype_word(logic [4:0] rd, logic [19:0] imm);
      return {imm, rd, 7'(OP_LUI)};
   endfunction

   function automatic entry_t table_entry(logic [31:0] insn, logic [XLEN-1:0] pc,
                                          logic wen, logic [4:0] rd,
                                          logic [XLEN-1:0] wdata);
      entry_t e;
      e.insn  = insn;
      e.pc    = pc;
      e.wen   = wen;
      e.rd    = rd;
      e.wdata = wdata;
      return e;
   endfunction

   `include "tb_program.svh"

   localparam int TIMEOUT_CYCLES = NUM_ENTRIES + 40;

   sim_top #(.IRAM_AW(IRAM_AW), .DRAM_AW(DRAM_AW)) dut
   (
      .clock          (clock),
      .rst            (rst),
      .i_run          (run),
      .i_load_we      (load_we),
      .i_load_addr    (load_addr),
      .i_load_insn    (load_insn),
      .o_commit_valid (commit_valid),
      .o_commit_pc    (commit_pc),
      .o_commit_insn  (commit_insn),
      .o_commit_wen   (commit_wen),
      .o_commit_rd    (commit_rd),
      .o_commit_wdata (commit_wdata),
      .o_trap_valid   (trap_valid),
      .o_trap_code    (trap_code),
      .o_cycle_cnt    (cycle_cnt),
      .o_instr_cnt    (instr_cnt)
   );

   always #20 clock = ~clock;

   task automatic stop_on_failure();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic compare_value(string name, logic [XLEN-1:0] got,
                                logic [XLEN-1:0] expected);
      assert (got === expected)
      else
      begin
         $display("Error: time %0d ns, %s is 0x%0h, expected 0x%0h",
                  $time, name, got, expected);
         stop_on_failure();
      end
   endtask

   task automatic check_commit();
      entry_t want;
      logic   is_trap;
      if (trap_seen || commit_idx >= NUM_ENTRIES)
      begin
         $display("A commit of pc %0d arrived after the trap", commit_pc);
         stop_on_failure();
      end
      else
      begin
         want    = prog_table[commit_idx];
         is_trap = (want.insn[6:0] == TRAP_OPCODE);
         compare_value("o_commit_pc", commit_pc, want.pc);
         compare_value("o_commit_insn", commit_insn, want.insn);
         compare_value("o_commit_wen", commit_wen, want.wen);
         // rd and wdata only mean something when a register is written.
         if (want.wen)
         begin
            compare_value("o_commit_rd", commit_rd, want.rd);
            compare_value("o_commit_wdata", commit_wdata, want.wdata);
         end
         // Commits come back to back, so each one lands a cycle after the one before.
         if (commit_idx == 0)
            first_cycle = sample_cycle;
         compare_value("o_cycle_cnt", cycle_cnt, first_cycle + commit_idx);
         compare_value("o_trap_valid", trap_valid, is_trap);
         if (is_trap)
         begin
            compare_value("o_trap_code", trap_code, want.wdata[7:0]);
            compare_value("o_instr_cnt", instr_cnt, NUM_ENTRIES - 1);
            trap_seen = 1'b1;
         end
         commit_idx++;
      end
   endtask

   // Outputs change on the rising edge, so they are sampled on the falling one.
   always @(negedge clock)
   begin
      if (!rst)
      begin
         if (commit_valid)
            check_commit();
         else if (trap_valid)
         begin
            $display("A trap was reported without a commit");
            stop_on_failure();
         end
         sample_cycle++;
      end
   end

   always @(posedge clock)
   begin
      if (run)
      begin
         run_cycles <= run_cycles + 1;
         if (run_cycles >= TIMEOUT_CYCLES)
         begin
            $display("Timeout: no trap was reported within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
         end
      end
   end

   initial
   begin
      clock        = 1'b0;
      rst          = 1'b1;
      run          = 1'b0;
      load_we      = 1'b0;
      load_addr    = '0;
      load_insn    = '0;
      commit_idx   = 0;
      run_cycles   = 0;
      trap_seen    = 1'b0;
      sample_cycle = 0;
      first_cycle  = 0;
      fill_table();

      repeat (8) @(posedge clock);
      rst <= 1'b0;
      @(negedge clock);
      compare_value("o_commit_valid", commit_valid, 1'b0);
      compare_value("o_trap_valid", trap_valid, 1'b0);
      compare_value("o_cycle_cnt", cycle_cnt, 0);
      compare_value("o_instr_cnt", instr_cnt, 0);

      // The word after the trap gets fetched but must never retire.
      for (int i = 0; i <= NUM_ENTRIES; i++)
      begin
         @(posedge clock);
         load_we   <= 1'b1;
         load_addr <= IRAM_AW'(i);
         if (i < NUM_ENTRIES)
            load_insn <= prog_table[i].insn;
         else
            load_insn <= itype_word(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd1);
      end
      @(posedge clock);
      load_we <= 1'b0;
      run     <= 1'b1;

      wait (trap_seen);
      // A dropped instruction behind the trap would show up within two cycles.
      repeat (4) @(posedge clock);
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim_top.f
+incdir+verif
rtl/core_pkg.sv
rtl/trace_pkg.sv
rtl/exec_wb_if.sv
rtl/instr_mem.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/commit_monitor.sv
rtl/sim_top.sv
verif/tb_sim_top.sv
